/* cam_frame.f */
+incdir+common
common/cam_pkg.sv
common/disp_pkg.sv
capture/cmos_pixel_pack.sv
fbuf/frame_store.sv
verilog/disp_timing_gen.sv
verilog/cam_frame_top.sv
bench/tb_cam_frame.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cam_frame
FILELIST  ?= cam_frame.f
MDIR      ?= obj_dir

SIM  := $(MDIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard common/*.svh)
PASS := Finished with no errors

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --Mdir $(MDIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(MDIR)

/* bench/tb_cam_frame.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module tb_cam_frame;

    localparam int PIX_PER_FRAME   = `FRAME_W * `FRAME_H;
    localparam int BYTES_PER_FRAME = `FRAME_H * (2 * `FRAME_W + 1);
    localparam int TIMEOUT_CYCLES  = 2 * 4 * BYTES_PER_FRAME + 6 * `H_TOTAL * `V_TOTAL + 200;
    localparam int SKIP            = 2;         // display frame not compared

    logic                 core_clk;
    logic                 i_reset;
    cam_pkg::cmos_byte_t  i_cmos;
    logic                 o_frame_ready;
    disp_pkg::video_out_t o_video;

    logic [23:0] ref_img [2 * PIX_PER_FRAME];   // both images already zero filled
    int          error_count = 0;
    int          cycle_cnt = 0;
    logic        first_frame_sent;
    logic        cap_busy;                      // second image being captured
    logic        cur_ref;
    logic        hs_q;
    logic        vs_q;
    logic        de_q;
    logic        ready_q;
    logic        hs_seen;
    int          hs_gap;
    int          de_run;
    int          de_lines;
    int          pix_idx;                       // raster position inside a frame
    int          frame_sel;
    int          sel_now;
    int          px_sel;
    int          pix_checked;
    int          lines_seen;
    int          frames_a;
    int          frames_b;
    logic [23:0] exp_rgb;
    logic [3:0]  idle_bits;
    logic        hs_rise;
    logic        vs_rise;
    logic        de_fall;

    cam_frame_top u_cam_frame_top
    (
        .core_clk      (core_clk),
        .i_reset       (i_reset),
        .i_cmos        (i_cmos),
        .o_frame_ready (o_frame_ready),
        .o_video       (o_video)
    );

    always #50 core_clk = ~core_clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [23:0] expected_rgb(input logic [7:0] hi, input logic [7:0] lo);
        logic [15:0]      word;
        cam_pkg::rgb565_t pix;
        word  = {hi, lo};
        pix.r = word[4:0];                      // low bits end up as red
        pix.g = word[10:5];
        pix.b = word[15:11];
        return {pix.r, 3'b000, pix.g, 2'b00, pix.b, 3'b000};
    endfunction

    task automatic next_cycle();
        @(posedge core_clk);
        #5;
    endtask

    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = int'($urandom_range(2, 0));
        repeat (gap) next_cycle();
        i_cmos.valid = 1'b1;
        i_cmos.data  = b;
        next_cycle();
        i_cmos.valid = 1'b0;
        i_cmos.data  = 8'($urandom);            // junk while not valid
    endtask

    task automatic capture_frame(input logic img);
        logic [7:0] hi;
        logic [7:0] lo;
        i_cmos.vsync = 1'b1;
        repeat (2) next_cycle();
        i_cmos.vsync = 1'b0;
        repeat (2) next_cycle();
        for (int line = 0; line < `FRAME_H; line++)
        begin
            i_cmos.href = 1'b1;
            for (int px = 0; px < `FRAME_W; px++)
            begin
                hi = 8'($urandom);
                lo = 8'($urandom);
                send_byte(hi);
                send_byte(lo);
                ref_img[{img, 7'(line * `FRAME_W + px)}] = expected_rgb(hi, lo);
                if (!img && line == `FRAME_H - 1 && px == `FRAME_W - 1)
                begin
                    first_frame_sent = 1'b1;
                end
            end
            send_byte(8'($urandom));            // odd byte that must be dropped
            i_cmos.href = 1'b0;
            repeat (3) next_cycle();
        end
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] got);
        error_count++;
        $display("** Error: %s expected 0x%0h got 0x%0h at cycle %0d",
                 name, expected, got, cycle_cnt);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("error: %s at cycle %0d", what, cycle_cnt);
    endtask

    task automatic print_summary();
        $display("pixels checked %0d, lines %0d, frames of image 1 %0d, of image 2 %0d, errors %0d",
                 pix_checked, lines_seen, frames_a, frames_b, error_count);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////

    assign hs_rise   = o_video.hs && !hs_q;
    assign vs_rise   = o_video.vs && !vs_q;
    assign de_fall   = de_q && !o_video.de;
    assign idle_bits = {o_frame_ready, o_video.vs, o_video.hs, o_video.de};
    assign sel_now   = cap_busy ? SKIP : int'(cur_ref);
    assign px_sel    = (pix_idx == 0) ? sel_now : frame_sel; // chosen at first de
    assign exp_rgb   = ref_img[{px_sel[0], pix_idx[6:0]}];

    always_ff @(posedge core_clk)
    begin
        if (i_reset)
        begin
            hs_q        <= 1'b0;
            vs_q        <= 1'b0;
            de_q        <= 1'b0;
            ready_q     <= 1'b0;
            hs_seen     <= 1'b0;
            hs_gap      <= 0;
            de_run      <= 0;
            de_lines    <= 0;
            pix_idx     <= 0;
            frame_sel   <= SKIP;
            pix_checked <= 0;
            lines_seen  <= 0;
            frames_a    <= 0;
            frames_b    <= 0;
        end
        else
        begin
            hs_q    <= o_video.hs;
            vs_q    <= o_video.vs;
            de_q    <= o_video.de;
            ready_q <= o_frame_ready;
            if (hs_rise)
            begin
                hs_gap  <= 1;
                hs_seen <= 1'b1;
            end
            else
            begin
                hs_gap <= hs_gap + 1;
            end
            if (o_video.de)
            begin
                de_run  <= de_q ? de_run + 1 : 1;
                pix_idx <= pix_idx + 1;
                if (pix_idx == 0)
                begin
                    frame_sel <= sel_now;
                end
                if (px_sel != SKIP)
                begin
                    pix_checked <= pix_checked + 1;
                end
            end
            if (de_fall)
            begin
                de_lines   <= de_lines + 1;
                lines_seen <= lines_seen + 1;
            end
            if (vs_rise)
            begin
                pix_idx   <= 0;
                de_lines  <= 0;
                frame_sel <= SKIP;
                frames_a  <= frames_a + int'(frame_sel == 0);
                frames_b  <= frames_b + int'(frame_sel == 1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_idle_before_frame: assert property (@(posedge core_clk) disable iff (i_reset)
        !first_frame_sent |-> (idle_bits == 4'h0))
        else report_value("o_frame_ready/vs/hs/de", 32'h0, 32'($sampled(idle_bits)));

    a_ready_sticky: assert property (@(posedge core_clk) disable iff (i_reset)
        ready_q |-> o_frame_ready)
        else report_value("o_frame_ready", 32'h1, 32'($sampled(o_frame_ready)));

    a_pixel_value: assert property (@(posedge core_clk) disable iff (i_reset)
        (o_video.de && px_sel != SKIP) |-> (o_video.rgb == exp_rgb))
        else report_value("o_video.rgb", 32'($sampled(exp_rgb)), 32'($sampled(o_video.rgb)));

    a_pixels_per_frame: assert property (@(posedge core_clk) disable iff (i_reset)
        o_video.de |-> (pix_idx < PIX_PER_FRAME))
        else report_failure("more de pixels in one frame than the frame holds");

    a_hs_period: assert property (@(posedge core_clk) disable iff (i_reset)
        (hs_rise && hs_seen) |-> (hs_gap == `H_TOTAL))
        else report_value("o_video.hs period", 32'(`H_TOTAL), 32'($sampled(hs_gap)));

    a_de_per_line: assert property (@(posedge core_clk) disable iff (i_reset)
        de_fall |-> (de_run == `H_ACTIVE))
        else report_value("o_video.de per line", 32'(`H_ACTIVE), 32'($sampled(de_run)));

    a_lines_per_frame: assert property (@(posedge core_clk) disable iff (i_reset)
        vs_rise |-> (de_lines == `V_ACTIVE))
        else report_value("o_video.de lines", 32'(`V_ACTIVE), 32'($sampled(de_lines)));

    a_de_in_blank: assert property (@(posedge core_clk) disable iff (i_reset)
        o_video.de |-> !(o_video.hs || o_video.vs))
        else report_value("o_video.hs/vs with de", 32'h0,
                          32'({$sampled(o_video.hs), $sampled(o_video.vs)}));

    ////////////////////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge core_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not complete within %0d cycles", cycle_cnt);
            print_summary();
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(65741));
        core_clk         = 1'b0;
        i_reset          = 1'b1;
        i_cmos           = '0;
        first_frame_sent = 1'b0;
        cap_busy         = 1'b0;
        cur_ref          = 1'b0;
        repeat (8) @(posedge core_clk);
        #5;
        i_reset = 1'b0;
        capture_frame(1'b0);
        while (!o_frame_ready)
        begin
            next_cycle();
        end
        while (frames_a < 2)
        begin
            next_cycle();
        end
        // new image lands while the display keeps running
        cap_busy = 1'b1;
        capture_frame(1'b1);
        cur_ref  = 1'b1;
        cap_busy = 1'b0;
        while (frames_b < 2)
        begin
            next_cycle();
        end
        repeat (4) next_cycle();
        print_summary();
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* verilog/cam_frame_top.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module cam_frame_top
(
    input  logic                 core_clk,
    input  logic                 i_reset,
    input  cam_pkg::cmos_byte_t  i_cmos,
    output logic                 o_frame_ready,
    output disp_pkg::video_out_t o_video
);

    cam_pkg::pix_wr_t  wr;                      // capture to store
    disp_pkg::pix_rd_t rd;                      // display to store
    cam_pkg::rgb565_t  rd_pixel;

    ////////////////////////////////////////////////////////////////////////////
    // camera byte packing
    ////////////////////////////////////////////////////////////////////////////

    cmos_pixel_pack u_pack
    (
        .core_clk      (core_clk),
        .i_reset       (i_reset),
        .i_cmos        (i_cmos),
        .o_wr          (wr)
    );

    frame_store u_store
    (
        .core_clk      (core_clk),
        .i_reset       (i_reset),
        .i_wr          (wr),
        .i_rd          (rd),
        .o_rd_pixel    (rd_pixel),
        .o_frame_ready (o_frame_ready)
    );

    // display side
    disp_timing_gen u_disp
    (
        .core_clk      (core_clk),
        .i_reset       (i_reset),
        .i_frame_ready (o_frame_ready),
        .o_rd          (rd),
        .i_rd_pixel    (rd_pixel),
        .o_video       (o_video)
    );

endmodule

/* verilog/disp_timing_gen.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module disp_timing_gen
(
    input  logic                 core_clk,
    input  logic                 i_reset,
    input  logic                 i_frame_ready,
    output disp_pkg::pix_rd_t    o_rd,
    input  cam_pkg::rgb565_t     i_rd_pixel,
    output disp_pkg::video_out_t o_video
);

    localparam int HW = $clog2(`H_TOTAL);
    localparam int VW = $clog2(`V_TOTAL);
    localparam logic [HW-1:0] H_LAST = HW'(`H_TOTAL - 1);
    localparam logic [VW-1:0] V_LAST = VW'(`V_TOTAL - 1);

    logic                     running;          // set once a frame is stored
    logic [HW-1:0]            h_cnt;
    logic [VW-1:0]            v_cnt;
    disp_pkg::timing_region_e h_region;
    disp_pkg::timing_region_e v_region;
    logic                     rd_re;
    logic [`PIX_ADDR_W-1:0]   rd_addr;
    logic                     hs_d1;
    logic                     vs_d1;
    logic                     de_d1;

    // order inside a line or frame is active, front, sync, back
    function automatic disp_pkg::timing_region_e region_of(
        input int unsigned pos,
        input int unsigned n_act,
        input int unsigned n_front,
        input int unsigned n_sync
    );
        if (pos < n_act)
            return disp_pkg::ACTIVE;
        else if (pos < n_act + n_front)
            return disp_pkg::FRONT;
        else if (pos < n_act + n_front + n_sync)
            return disp_pkg::SYNC;
        else
            return disp_pkg::BACK;
    endfunction

    // zero fill of the low bits
    function automatic disp_pkg::rgb888_t expand(input cam_pkg::rgb565_t pix);
        return '{r: {pix.r, 3'b000}, g: {pix.g, 2'b00}, b: {pix.b, 3'b000}};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (i_reset)
        begin
            running <= 1'b0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end
        else if (!running)
        begin
            running <= i_frame_ready;           // counters wait at 0,0
        end
        else if (h_cnt == H_LAST)
        begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_region = region_of(32'(h_cnt), `H_ACTIVE, `H_FRONT, `H_SYNC);
    assign v_region = region_of(32'(v_cnt), `V_ACTIVE, `V_FRONT, `V_SYNC);

    ////////////////////////////////////////////////////////////////////////////
    // pixel fetch, two cycles ahead of de
    ////////////////////////////////////////////////////////////////////////////

    assign rd_re = running && h_region == disp_pkg::ACTIVE
                           && v_region == disp_pkg::ACTIVE;

    always_ff @(posedge core_clk)
    begin
        if (i_reset)
        begin
            rd_addr <= '0;
        end
        else if (running && h_cnt == H_LAST && v_cnt == V_LAST)
        begin
            rd_addr <= '0;                      // raster restarts
        end
        else if (rd_re)
        begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    assign o_rd = '{re: rd_re, addr: rd_addr};

    ////////////////////////////////////////////////////////////////////////////
    // sync pipeline matched to the memory read
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (i_reset)
        begin
            hs_d1   <= 1'b0;
            vs_d1   <= 1'b0;
            de_d1   <= 1'b0;
            o_video <= '0;
        end
        else
        begin
            hs_d1   <= running && h_region == disp_pkg::SYNC;
            vs_d1   <= running && v_region == disp_pkg::SYNC;
            de_d1   <= rd_re;                   // pixel arrives next cycle
            o_video <= '{vs: vs_d1, hs: hs_d1, de: de_d1,
                         rgb: de_d1 ? expand(i_rd_pixel) : '0};
        end
    end

    a_de_outside_sync: assert property (@(posedge core_clk) disable iff (i_reset)
        o_video.de |-> !(o_video.hs || o_video.vs))
        else $error("de high during a sync pulse");

endmodule

/* fbuf/frame_store.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module frame_store
(
    input  logic              core_clk,
    input  logic              i_reset,
    input  cam_pkg::pix_wr_t  i_wr,
    input  disp_pkg::pix_rd_t i_rd,
    output cam_pkg::rgb565_t  o_rd_pixel,
    output logic              o_frame_ready
);

    localparam int unsigned DEPTH = `FRAME_W * `FRAME_H;
    localparam logic [`PIX_ADDR_W-1:0] LAST_ADDR = `PIX_ADDR_W'(DEPTH - 1);

    cam_pkg::rgb565_t mem [DEPTH];              // one whole frame
    logic             ready_q;

    ////////////////////////////////////////////////////////////////////////////
    // pixel memory, write and read ports are independent
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (i_wr.we)
        begin
            mem[i_wr.addr] <= i_wr.pixel;
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (i_rd.re)
        begin
            o_rd_pixel <= mem[i_rd.addr];       // data one cycle after strobe
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame ready flag
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (i_reset)
        begin
            ready_q <= 1'b0;
        end
        else if (i_wr.we && i_wr.frame_end)
        begin
            ready_q <= 1'b1;                    // sticky until reset
        end
    end

    assign o_frame_ready = ready_q;

    // display must wait for a complete frame
    a_no_early_read: assert property (@(posedge core_clk) disable iff (i_reset)
        i_rd.re |-> o_frame_ready)
        else $error("pixel read before the first frame was stored");

    // frame end only marks the write of the last pixel
    a_frame_end_addr: assert property (@(posedge core_clk) disable iff (i_reset)
        i_wr.frame_end |-> (i_wr.we && i_wr.addr == LAST_ADDR))
        else $error("frame end flagged at address 0x%0h", i_wr.addr);

endmodule

/* capture/cmos_pixel_pack.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module cmos_pixel_pack
(
    input  logic                core_clk,
    input  logic                i_reset,
    input  cam_pkg::cmos_byte_t i_cmos,
    output cam_pkg::pix_wr_t    o_wr
);

    localparam logic [`PIX_ADDR_W-1:0] LAST_ADDR = `PIX_ADDR_W'(`FRAME_W * `FRAME_H - 1);

    cam_pkg::pack_phase_e   phase;
    logic                   vsync_q;            // previous vsync level
    logic [7:0]             hi_byte;
    logic [`PIX_ADDR_W-1:0] wr_addr;            // next address to write
    logic                   frame_full;         // last address already written
    logic                   wr_we;
    logic                   wr_end;
    logic [`PIX_ADDR_W-1:0] wr_addr_q;
    cam_pkg::rgb565_t       wr_pixel;
    logic                   byte_ok;
    logic                   vs_rise;
    logic                   pix_done;
    logic [15:0]            word;

    assign byte_ok  = i_cmos.valid & i_cmos.href;
    assign vs_rise  = i_cmos.vsync & ~vsync_q;
    assign pix_done = byte_ok & ~vs_rise & (phase == cam_pkg::WAIT_LOW);
    assign word     = {hi_byte, i_cmos.data};   // high byte arrives first

    ////////////////////////////////////////////////////////////////////////////
    // phase and address control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (i_reset)
        begin
            phase      <= cam_pkg::WAIT_HIGH;
            vsync_q    <= 1'b0;
            wr_addr    <= '0;
            frame_full <= 1'b0;
            wr_we      <= 1'b0;
            wr_end     <= 1'b0;
        end
        else
        begin
            vsync_q <= i_cmos.vsync;
            wr_we   <= pix_done;
            wr_end  <= pix_done & (wr_addr == LAST_ADDR);
            if (vs_rise)
            begin
                phase      <= cam_pkg::WAIT_HIGH;  // new frame starts at 0
                wr_addr    <= '0;
                frame_full <= 1'b0;
            end
            else if (!i_cmos.href)
            begin
                phase <= cam_pkg::WAIT_HIGH;    // drops an odd trailing byte
            end
            else if (byte_ok)
            begin
                unique case (phase)
                    cam_pkg::WAIT_HIGH: phase <= cam_pkg::WAIT_LOW;
                    cam_pkg::WAIT_LOW:
                    begin
                        phase <= cam_pkg::WAIT_HIGH;
                        if (wr_addr != LAST_ADDR)
                        begin
                            wr_addr <= wr_addr + 1'b1; // holds at the end
                        end
                        else
                        begin
                            frame_full <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // byte and pixel payload
    always_ff @(posedge core_clk)
    begin
        if (byte_ok && phase == cam_pkg::WAIT_HIGH)
        begin
            hi_byte <= i_cmos.data;
        end
        if (pix_done)
        begin
            wr_addr_q <= wr_addr;
            // colour fields swap ends so low bits are red
            wr_pixel  <= '{r: word[4:0], g: word[10:5], b: word[15:11]};
        end
    end

    assign o_wr = '{we: wr_we, addr: wr_addr_q, pixel: wr_pixel, frame_end: wr_end};

    a_addr_in_frame: assert property (@(posedge core_clk) disable iff (i_reset)
        pix_done |-> !frame_full)
        else $error("pixel write past the end of the frame at address 0x%0h", wr_addr);

endmodule

/* common/disp_pkg.sv */
`include "video_defines.svh"

package disp_pkg;

    // region of a line or of a frame
    typedef enum logic [1:0] {
        ACTIVE,
        FRONT,
        SYNC,
        BACK
    } timing_region_e;

    // expanded colour, 8 bits per channel
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // display output bundle
    typedef struct packed {
        logic    vs;                            // active high
        logic    hs;                            // active high
        logic    de;
        rgb888_t rgb;
    } video_out_t;

    // read request from the display side
    typedef struct packed {
        logic                   re;
        logic [`PIX_ADDR_W-1:0] addr;
    } pix_rd_t;

endpackage

/* common/cam_pkg.sv */
`include "video_defines.svh"

package cam_pkg;

    // one camera byte as sampled on core_clk
    typedef struct packed {
        logic       vsync;                      // frame sync level
        logic       href;                       // line valid level
        logic       valid;                      // byte strobe
        logic [7:0] data;
    } cmos_byte_t;

    // packed pixel as stored in the frame buffer
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // write request from the capture side
    typedef struct packed {
        logic                   we;             // one pulse per pixel
        logic [`PIX_ADDR_W-1:0] addr;
        rgb565_t                pixel;
        logic                   frame_end;      // with the last pixel write
    } pix_wr_t;

    // which byte of the pair is expected next
    typedef enum logic {
        WAIT_HIGH,
        WAIT_LOW
    } pack_phase_e;

endpackage

/* common/video_defines.svh */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// frame store geometry
////////////////////////////////////////////////////////////////////////////

`define FRAME_W     16                          // pixels per line
`define FRAME_H     8                           // lines per frame
`define PIX_ADDR_W  7                           // covers FRAME_W * FRAME_H

////////////////////////////////////////////////////////////////////////////
// display timing, all counts in core_clk cycles
////////////////////////////////////////////////////////////////////////////

`define H_ACTIVE    `FRAME_W
`define H_FRONT     2
`define H_SYNC      3
`define H_BACK      3
`define H_TOTAL     (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE    `FRAME_H
`define V_FRONT     1
`define V_SYNC      2
`define V_BACK      1
`define V_TOTAL     (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`endif
